/* Makefile */
# Verilator build and run for the reservation station testbench
TOP = tb_rs

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir

# Pass only if the log holds the pass message
run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only -Wall +incdir+. rs_pkg.sv rs_issue_if.sv rs_occupancy_counter.sv \
		rs_entry_array.sv rs_issue_select.sv rs_top.sv --top-module rs_top

clean:
	rm -rf obj_dir sim.log

/* rs_defines.svh */
// Sizing macros for the station; the index width must stay the log2 of a power-of-two entry count
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// ----------------------------------------
// Station geometry
// ----------------------------------------
// Number of entries in the station
`define RS_ENTRY_NUM 8

// Entry index width
`define RS_IDX_W $clog2(`RS_ENTRY_NUM)

// ----------------------------------------
// Instruction payload widths
// ----------------------------------------
// Physical register tag
`define RS_TAG_W 6
// Reorder buffer index
`define RS_ROB_W 5
// Opcode carried through untouched
`define RS_OP_W 8

`endif

/* rs_entry_array.sv */
// One dispatch per cycle; squash beats dispatch and a same-cycle broadcast wakes the new entry
`include "rs_defines.svh"

module rs_entry_array import rs_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                flush_i,
    input  logic                dp_valid_i,
    input  logic                dp_ready_i,
    input  logic                cdb_valid_i,
    input  rs_inst_t            dp_inst_i,
    input  logic [`RS_TAG_W-1:0] cdb_tag_i,
    output logic                dp_fire_o,
    rs_issue_if.entry           iss
);

    localparam int N = `RS_ENTRY_NUM;

    // Control state
    logic [N-1:0]     valid_q;
    // Instruction payload per slot
    rs_inst_t [N-1:0] inst_q;

    logic [N-1:0]     release_vec;
    logic [N-1:0]     free_vec;
    logic [N-1:0]     dp_sel;
    logic [N-1:0]     wake1;
    logic [N-1:0]     wake2;
    rs_idx_t          alloc_idx;
    logic             alloc_found;
    rs_inst_t         dp_inst_woken;

    // ----------------------------------------
    // Free slot search
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < N; i++) begin
            // Slot leaving this cycle through issue
            release_vec[i] = iss.issue_fire && (iss.issue_idx == rs_idx_t'(i));
            free_vec[i]    = !valid_q[i] || release_vec[i];
        end
    end

    // Downward scan so the lowest free index wins
    always_comb begin
        alloc_found = 1'b0;
        alloc_idx   = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (free_vec[i]) begin
                alloc_found = 1'b1;
                alloc_idx   = rs_idx_t'(i);
            end
        end
    end

    assign dp_fire_o = dp_valid_i && dp_ready_i;

    // One-hot write select
    always_comb begin
        for (int i = 0; i < N; i++) begin
            dp_sel[i] = dp_fire_o && (alloc_idx == rs_idx_t'(i));
        end
    end

    // ----------------------------------------
    // Tag wakeup
    // ----------------------------------------
    // Incoming instruction sees the same broadcast
    always_comb begin
        dp_inst_woken = dp_inst_i;
        if (cdb_valid_i && (dp_inst_i.src1_tag == cdb_tag_i)) begin
            dp_inst_woken.src1_ready = 1'b1;
        end
        if (cdb_valid_i && (dp_inst_i.src2_tag == cdb_tag_i)) begin
            dp_inst_woken.src2_ready = 1'b1;
        end
    end

    // Only valid stored entries match
    always_comb begin
        for (int i = 0; i < N; i++) begin
            wake1[i] = cdb_valid_i && valid_q[i] && (inst_q[i].src1_tag == cdb_tag_i);
            wake2[i] = cdb_valid_i && valid_q[i] && (inst_q[i].src2_tag == cdb_tag_i);
        end
    end

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            // Squash also drops the incoming dispatch
            valid_q <= '0;
        end else begin
            for (int i = 0; i < N; i++) begin
                // Dispatch may reuse a slot issued this cycle
                if (dp_sel[i]) begin
                    valid_q[i] <= 1'b1;
                end else if (release_vec[i]) begin
                    valid_q[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < N; i++) begin
            if (dp_sel[i]) begin
                inst_q[i] <= dp_inst_woken;
            end else begin
                // Sources wake independently
                if (wake1[i]) begin
                    inst_q[i].src1_ready <= 1'b1;
                end
                if (wake2[i]) begin
                    inst_q[i].src2_ready <= 1'b1;
                end
            end
        end
    end

    // Snapshot toward the selector
    always_comb begin
        for (int i = 0; i < N; i++) begin
            iss.entries[i].valid = valid_q[i];
            iss.entries[i].inst  = inst_q[i];
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Selector never picks an empty slot
    a_issue_valid: assert property (
        @(posedge clk_i) disable iff (rst_i)
        iss.issue_fire |-> valid_q[iss.issue_idx]
    );

    // Counter and array agree on free space
    a_fire_slot: assert property (
        @(posedge clk_i) disable iff (rst_i)
        dp_fire_o |-> alloc_found
    );

    // Dispatch offered while full is dropped
    a_dp_ready: assert property (
        @(posedge clk_i) disable iff (rst_i)
        dp_valid_i |-> dp_ready_i
    ) else $warning("dispatch offered while the station is full");

endmodule

/* rs_issue_if.sv */
// Entry state toward the selector and the single pick back; issue_fire implies a valid ready entry
`include "rs_defines.svh"

interface rs_issue_if import rs_pkg::*; ();

    // ----------------------------------------
    // Array to selector
    // ----------------------------------------
    // Full snapshot of every slot, registered in the array
    rs_entry_t [`RS_ENTRY_NUM-1:0] entries;

    // ----------------------------------------
    // Selector to array
    // ----------------------------------------
    // One-cycle strobe, entry leaves at the next edge
    logic                          issue_fire;
    // Slot being issued, meaningful only with the strobe
    rs_idx_t                       issue_idx;

    // Storage side
    modport entry (
        output entries,
        input  issue_fire,
        input  issue_idx
    );

    // Pick side
    modport select (
        input  entries,
        output issue_fire,
        output issue_idx
    );

endinterface

/* rs_issue_select.sv */
// Single-issue pick, lowest ready index first; issue output is all zero when nothing fires
`include "rs_defines.svh"

module rs_issue_select import rs_pkg::*; (
    input  logic       alu_ready_i,
    input  logic       mem_ready_i,
    rs_issue_if.select iss,
    output logic       is_valid_o,
    output rs_inst_t   is_inst_o
);

    localparam int N = `RS_ENTRY_NUM;

    logic [N-1:0] fu_ok_vec;
    logic [N-1:0] rdy_vec;
    rs_idx_t      pick_idx;
    logic         pick_found;

    // ----------------------------------------
    // Ready-to-issue check
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < N; i++) begin
            // Unit availability by class
            fu_ok_vec[i] = (iss.entries[i].inst.fu == FU_MEM) ? mem_ready_i : alu_ready_i;
            rdy_vec[i]   = iss.entries[i].valid
                        && iss.entries[i].inst.src1_ready
                        && iss.entries[i].inst.src2_ready
                        && fu_ok_vec[i];
        end
    end

    // ----------------------------------------
    // Lowest index pick
    // ----------------------------------------
    always_comb begin
        pick_found = 1'b0;
        pick_idx   = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (rdy_vec[i]) begin
                pick_found = 1'b1;
                pick_idx   = rs_idx_t'(i);
            end
        end
    end

    assign iss.issue_fire = pick_found;
    assign iss.issue_idx  = pick_idx;

    // ----------------------------------------
    // Issue port
    // ----------------------------------------
    assign is_valid_o = pick_found;

    // Zero payload keeps the port quiet when idle
    always_comb begin
        if (pick_found) begin
            is_inst_o = iss.entries[pick_idx].inst;
        end else begin
            is_inst_o = '0;
        end
    end

endmodule

/* rs_occupancy_counter.sv */
// Occupancy count for one dispatch and one issue per cycle; a same-cycle issue frees a slot
`include "rs_defines.svh"

module rs_occupancy_counter import rs_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    input  logic flush_i,
    input  logic dp_fire_i,
    input  logic is_fire_i,
    output logic dp_ready_o
);

    // Wide enough to hold the full entry count
    localparam int CNT_W = $clog2(`RS_ENTRY_NUM + 1);

    logic [CNT_W-1:0] cnt_q;

    // ----------------------------------------
    // Count register
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (flush_i) begin
            // Squash empties the whole station
            cnt_q <= '0;
        end else begin
            // Plus one on dispatch, minus one on issue
            cnt_q <= cnt_q + CNT_W'(dp_fire_i) - CNT_W'(is_fire_i);
        end
    end

    // ----------------------------------------
    // Dispatch readiness
    // ----------------------------------------
    // Free slot now, or one being released by this cycle's issue
    assign dp_ready_o = (cnt_q < CNT_W'(`RS_ENTRY_NUM)) || is_fire_i;

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Count stays within the array size
    a_cnt_max: assert property (
        @(posedge clk_i) disable iff (rst_i)
        cnt_q <= CNT_W'(`RS_ENTRY_NUM)
    );

    // No issue out of an empty station unless refilled in the same cycle
    a_cnt_min: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (cnt_q == '0) |-> !(is_fire_i && !dp_fire_i)
    );

endmodule

/* rs_pkg.sv */
// Shared station types; field widths come from rs_defines.svh and no field is decoded two ways
`include "rs_defines.svh"

package rs_pkg;

    // ----------------------------------------
    // Functional unit class
    // ----------------------------------------
    // Only two unit classes remain
    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MEM = 1'b1
    } fu_class_e;

    // ----------------------------------------
    // Decoded instruction
    // ----------------------------------------
    // Issue carries tags only, operand values are read later
    typedef struct packed {
        // Destination physical register
        logic [`RS_TAG_W-1:0] dst_tag;
        // First source and its ready flag
        logic [`RS_TAG_W-1:0] src1_tag;
        logic                 src1_ready;
        // Second source and its ready flag
        logic [`RS_TAG_W-1:0] src2_tag;
        logic                 src2_ready;
        // Unit the instruction needs
        fu_class_e            fu;
        // Opaque opcode for the unit
        logic [`RS_OP_W-1:0]  opcode;
        // Slot in the reorder buffer
        logic [`RS_ROB_W-1:0] rob_idx;
    } rs_inst_t;

    // One station slot
    typedef struct packed {
        logic     valid;
        rs_inst_t inst;
    } rs_entry_t;

    // Entry index
    typedef logic [`RS_IDX_W-1:0] rs_idx_t;

endpackage

/* rs_top.sv */
// Reservation station top for one thread; issue carries tags only and flush_i squashes everything
`include "rs_defines.svh"

module rs_top import rs_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    // Dispatch side
    input  logic                 dp_valid_i,
    input  rs_inst_t             dp_inst_i,
    output logic                 dp_ready_o,
    // Completion bus
    input  logic                 cdb_valid_i,
    input  logic [`RS_TAG_W-1:0] cdb_tag_i,
    // Unit availability
    input  logic                 alu_ready_i,
    input  logic                 mem_ready_i,
    // Squash
    input  logic                 flush_i,
    // Issue side
    output logic                 is_valid_o,
    output rs_inst_t             is_inst_o
);

    // Accepted dispatch this cycle
    logic dp_fire;

    // ----------------------------------------
    // Array to selector link
    // ----------------------------------------
    rs_issue_if iss_if ();

    rs_occupancy_counter u_cnt (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .flush_i    (flush_i),
        .dp_fire_i  (dp_fire),
        .is_fire_i  (iss_if.issue_fire),
        .dp_ready_o (dp_ready_o)
    );

    rs_entry_array u_array (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .dp_valid_i  (dp_valid_i),
        .dp_ready_i  (dp_ready_o),
        .cdb_valid_i (cdb_valid_i),
        .dp_inst_i   (dp_inst_i),
        .cdb_tag_i   (cdb_tag_i),
        .dp_fire_o   (dp_fire),
        .iss         (iss_if.entry)
    );

    rs_issue_select u_select (
        .alu_ready_i (alu_ready_i),
        .mem_ready_i (mem_ready_i),
        .iss         (iss_if.select),
        .is_valid_o  (is_valid_o),
        .is_inst_o   (is_inst_o)
    );

endmodule

/* rs_trace.txt */
# test dp_v dst s1 r1 s2 r2 fu op rob cdb_v cdb_tag alu_rdy mem_rdy flush exp_dp_rdy exp_is_v exp_rob
# test number decimal, other columns hex; exp_rob is ignored when exp_is_v is 0
1 1 05 01 1 02 1 0 a5 01 0 00 1 1 0 1 0 00
1 0 00 00 0 00 0 0 00 00 0 00 1 1 0 1 1 01
1 0 00 00 0 00 0 0 00 00 0 00 1 1 0 1 0 00
2 1 06 0a 0 0b 0 0 11 02 1 0a 1 1 0 1 0 00
2 0 00 00 0 00 0 0 00 00 0 00 1 1 0 1 0 00
2 0 00 00 0 00 0 0 00 00 1 0c 1 1 0 1 0 00
2 0 00 00 0 00 0 0 00 00 1 0b 1 1 0 1 0 00
2 0 00 00 0 00 0 0 00 00 0 00 1 1 0 1 1 02
2 0 00 00 0 00 0 0 00 00 0 00 1 1 0 1 0 00
3 1 10 01 1 02 1 1 30 03 0 00 0 0 0 1 0 00
3 1 11 03 1 04 1 0 31 04 0 00 0 0 0 1 0 00
3 1 12 05 1 06 1 0 32 05 0 00 0 0 0 1 0 00
3 1 13 07 1 08 1 1 33 06 0 00 0 0 0 1 0 00
3 0 00 00 0 00 0 0 00 00 0 00 1 0 0 1 1 04
3 0 00 00 0 00 0 0 00 00 0 00 1 0 0 1 1 05
3 0 00 00 0 00 0 0 00 00 0 00 1 0 0 1 0 00
3 0 00 00 0 00 0 0 00 00 0 00 1 1 0 1 1 03
3 0 00 00 0 00 0 0 00 00 0 00 1 1 0 1 1 06
3 0 00 00 0 00 0 0 00 00 0 00 1 1 0 1 0 00
4 1 20 01 1 02 1 0 40 07 0 00 0 0 0 1 0 00
4 1 21 01 1 02 1 0 41 08 0 00 0 0 0 1 0 00
4 1 22 01 1 02 1 0 42 09 0 00 0 0 0 1 0 00
4 1 23 01 1 02 1 0 43 0a 0 00 0 0 0 1 0 00
4 1 24 01 1 02 1 0 44 0b 0 00 0 0 0 1 0 00
4 1 25 01 1 02 1 0 45 0c 0 00 0 0 0 1 0 00
4 1 26 01 1 02 1 0 46 0d 0 00 0 0 0 1 0 00
4 1 27 01 1 02 1 0 47 0e 0 00 0 0 0 1 0 00
4 0 00 00 0 00 0 0 00 00 0 00 0 0 0 0 0 00
4 1 28 01 1 02 1 0 48 0f 0 00 1 0 0 1 1 07
4 0 00 00 0 00 0 0 00 00 0 00 0 0 0 0 0 00
5 0 00 00 0 00 0 0 00 00 0 00 0 0 1 0 0 00
5 0 00 00 0 00 0 0 00 00 0 00 1 1 0 1 0 00
5 1 30 01 1 02 1 0 50 10 0 00 1 1 1 1 0 00
5 0 00 00 0 00 0 0 00 00 0 00 1 1 0 1 0 00
5 0 00 00 0 00 0 0 00 00 0 00 1 1 0 1 0 00

/* sim.f */
+incdir+.
rs_pkg.sv
rs_issue_if.sv
rs_occupancy_counter.sv
rs_entry_array.sv
rs_issue_select.sv
rs_top.sv
tb_rs.sv

/* tb_rs.sv */
// Replays rs_trace.txt from the project root; the trace must start from an empty station after reset
`include "rs_defines.svh"

module tb_rs import rs_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROB_NUM = 2 ** `RS_ROB_W;
    localparam int FIELDS  = 18;

    // One trace line, inputs plus expected outputs
    typedef struct {
        int                   test;
        logic                 dp_valid;
        rs_inst_t             inst;
        logic                 cdb_valid;
        logic [`RS_TAG_W-1:0] cdb_tag;
        logic                 alu_ready;
        logic                 mem_ready;
        logic                 flush;
        logic                 exp_dp_ready;
        logic                 exp_is_valid;
        logic [`RS_ROB_W-1:0] exp_rob;
    } step_t;

    logic                 clk_i;
    logic                 rst_i;
    logic                 dp_valid_i;
    rs_inst_t             dp_inst_i;
    logic                 dp_ready_o;
    logic                 cdb_valid_i;
    logic [`RS_TAG_W-1:0] cdb_tag_i;
    logic                 alu_ready_i;
    logic                 mem_ready_i;
    logic                 flush_i;
    logic                 is_valid_o;
    rs_inst_t             is_inst_o;

    step_t    steps[$];
    // Dispatched instructions by reorder index
    rs_inst_t rob_table [ROB_NUM];
    logic     rob_known [ROB_NUM];
    int       errors;
    int       test_errs;
    int       checks;
    int       tests_run;
    int       tests_failed;
    int       cycle_cnt;
    int       cycle_limit;
    logic     trace_loaded;

    rs_top uut (.*);

    // ----------------------------------------
    // Clock and cycle limit
    // ----------------------------------------
    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Trace length plus reset plus margin
    initial begin
        cycle_cnt = 0;
        wait (trace_loaded === 1'b1);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Simulation FAILED");
        $finish;
    end

    // ----------------------------------------
    // Trace handling
    // ----------------------------------------
    task automatic load_trace(output int ok);
        int    fd;
        int    n;
        int    lineno;
        int    f [FIELDS];
        string line;
        step_t s;
        ok = 0;
        lineno = 0;
        fd = $fopen("rs_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file rs_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                lineno++;
                // Skip blank and comment lines
                if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                    n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                                f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
                    if (n != FIELDS) begin
                        $display("trace line %0d is malformed", lineno);
                        errors++;
                    end else begin
                        s.test             = f[0];
                        s.dp_valid         = f[1][0];
                        s.inst.dst_tag     = f[2][`RS_TAG_W-1:0];
                        s.inst.src1_tag    = f[3][`RS_TAG_W-1:0];
                        s.inst.src1_ready  = f[4][0];
                        s.inst.src2_tag    = f[5][`RS_TAG_W-1:0];
                        s.inst.src2_ready  = f[6][0];
                        s.inst.fu          = fu_class_e'(f[7][0]);
                        s.inst.opcode      = f[8][`RS_OP_W-1:0];
                        s.inst.rob_idx     = f[9][`RS_ROB_W-1:0];
                        s.cdb_valid        = f[10][0];
                        s.cdb_tag          = f[11][`RS_TAG_W-1:0];
                        s.alu_ready        = f[12][0];
                        s.mem_ready        = f[13][0];
                        s.flush            = f[14][0];
                        s.exp_dp_ready     = f[15][0];
                        s.exp_is_valid     = f[16][0];
                        s.exp_rob          = f[17][`RS_ROB_W-1:0];
                        steps.push_back(s);
                    end
                end
            end
            $fclose(fd);
            if (steps.size() == 0) begin
                $display("the trace file holds no steps");
                errors++;
            end else begin
                ok = 1;
            end
        end
    endtask

    // Apply one line and remember what was dispatched
    task automatic drive_step(input step_t s);
        rst_i       = 1'b0;
        dp_valid_i  = s.dp_valid;
        dp_inst_i   = s.inst;
        cdb_valid_i = s.cdb_valid;
        cdb_tag_i   = s.cdb_tag;
        alu_ready_i = s.alu_ready;
        mem_ready_i = s.mem_ready;
        flush_i     = s.flush;
        if (s.dp_valid) begin
            rob_table[s.inst.rob_idx] = s.inst;
            rob_known[s.inst.rob_idx] = 1'b1;
        end
    endtask

    task automatic check_step(input step_t s);
        rs_inst_t exp_inst;
        // Idle issue port is all zero
        exp_inst = '0;
        if (s.exp_is_valid) begin
            if (!rob_known[s.exp_rob]) begin
                $display("trace expects rob %0d on the issue port but it was never dispatched",
                         s.exp_rob);
                test_errs++;
            end else begin
                // Issued fields unchanged, both sources ready by then
                exp_inst            = rob_table[s.exp_rob];
                exp_inst.src1_ready = 1'b1;
                exp_inst.src2_ready = 1'b1;
            end
        end
        checks += 3;
        if (dp_ready_o !== s.exp_dp_ready) begin
            $display("mismatch at %0t: dp_ready_o expected %0h actual %0h",
                     $time, s.exp_dp_ready, dp_ready_o);
            test_errs++;
        end
        if (is_valid_o !== s.exp_is_valid) begin
            $display("mismatch at %0t: is_valid_o expected %0h actual %0h",
                     $time, s.exp_is_valid, is_valid_o);
            test_errs++;
        end
        if (is_inst_o !== exp_inst) begin
            $display("mismatch at %0t: is_inst_o expected %h actual %h",
                     $time, exp_inst, is_inst_o);
            test_errs++;
        end
    endtask

    // One result line per test
    task automatic close_test(input int test);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d passed", test);
        end else begin
            tests_failed++;
            errors += test_errs;
            $display("test %0d failed with %0d errors", test, test_errs);
        end
        test_errs = 0;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int ok;
        int cur_test;
        rst_i        = 1'b1;
        dp_valid_i   = 1'b0;
        dp_inst_i    = '0;
        cdb_valid_i  = 1'b0;
        cdb_tag_i    = '0;
        alu_ready_i  = 1'b0;
        mem_ready_i  = 1'b0;
        flush_i      = 1'b0;
        errors       = 0;
        test_errs    = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        trace_loaded = 1'b0;
        for (int i = 0; i < ROB_NUM; i++) begin
            rob_known[i] = 1'b0;
        end
        load_trace(ok);
        cycle_limit  = steps.size() + 3 + 20;
        trace_loaded = 1'b1;
        // Reset over three rising edges
        repeat (3) @(posedge clk_i);
        if (ok != 0) begin
            cur_test = steps[0].test;
            foreach (steps[i]) begin
                if (steps[i].test != cur_test) begin
                    close_test(cur_test);
                    cur_test = steps[i].test;
                end
                @(negedge clk_i);
                drive_step(steps[i]);
                // Sample just before the rising edge
                #8;
                check_step(steps[i]);
            end
            close_test(cur_test);
        end
        @(negedge clk_i);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
